// ==== hdl/dma_pkg.sv ====
// --------------------------------------------------
// Shared widths, page constants and stream structs
// for the DMA burst legalizer. Modules reference
// everything here through scoped names.
// --------------------------------------------------
`default_nettype none

package dma_pkg;

    // Address and length widths
    localparam int unsigned AddrWidth     = 32;
    localparam int unsigned LenWidth      = 16;
    // Data beat geometry
    localparam int unsigned StrbWidth     = 4;
    localparam int unsigned OffsetWidth   = 2;
    // Bursts never cross this boundary
    localparam int unsigned PageSize      = 1024;
    localparam int unsigned PageAddrWidth = 10;
    localparam int unsigned BeatCntWidth  = 8;

    typedef logic [AddrWidth-1:0]     addr_t;
    typedef logic [LenWidth-1:0]      len_t;
    // One extra bit so a full page fits
    typedef logic [PageAddrWidth:0]   page_len_t;
    typedef logic [OffsetWidth-1:0]   offset_t;

    // 1D copy request
    typedef struct packed {
        len_t  length;
        addr_t src_addr;
        addr_t dst_addr;
        logic  decouple_rw;
    } xfer_req_t;

    // Read burst, beats is count minus one
    typedef struct packed {
        addr_t                   addr;
        logic [BeatCntWidth-1:0] beats;
        offset_t                 offset;
        offset_t                 tailer;
        page_len_t               num_bytes;
    } rd_burst_t;

    // Write burst, last marks end of transfer
    typedef struct packed {
        addr_t                   addr;
        logic [BeatCntWidth-1:0] beats;
        offset_t                 offset;
        offset_t                 tailer;
        page_len_t               num_bytes;
        logic                    last;
    } wr_burst_t;

    // Burst fields for num bytes starting at addr
    function automatic rd_burst_t form_burst(input addr_t addr, input page_len_t num);
        rd_burst_t                      b;
        offset_t                        off;
        logic [PageAddrWidth+1:0]       span;
        off         = addr[OffsetWidth-1:0];
        span        = {1'b0, num} + (PageAddrWidth+2)'(off);
        b.addr      = {addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
        b.beats     = BeatCntWidth'((span - 1) >> OffsetWidth);
        b.offset    = off;
        b.tailer    = span[OffsetWidth-1:0];
        b.num_bytes = num;
        return b;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/xfer_fifo.sv ====
// --------------------------------------------------
// Two-entry request queue in front of the splitter.
// Accepts a new transfer while the current one is
// still being split. Valid/ready on both sides.
// --------------------------------------------------
`default_nettype none

module xfer_fifo (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  dma_pkg::xfer_req_t push_req_i,
    input  logic              push_valid_i,
    output logic              push_ready_o,
    output dma_pkg::xfer_req_t pop_req_o,
    output logic              pop_valid_o,
    input  logic              pop_ready_i
);

    dma_pkg::xfer_req_t mem_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic [1:0] count_d;
    logic       ready_q;
    logic       push;
    logic       pop;

    assign push = push_valid_i & ready_q;
    assign pop  = pop_valid_o & pop_ready_i;

    // Fill level after this cycle
    assign count_d = count_q + {1'b0, push} - {1'b0, pop};

    // --------------------------------------------------
    // Pointers and fill count
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
            // Held low through reset
            ready_q  <= 1'b0;
        end else begin
            wr_ptr_q <= wr_ptr_q ^ push;
            rd_ptr_q <= rd_ptr_q ^ pop;
            count_q  <= count_d;
            ready_q  <= (count_d != 2'd2);
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_req_i;
        end
    end

    assign push_ready_o = ready_q;
    assign pop_valid_o  = (count_q != 2'd0);
    assign pop_req_o    = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hdl/side_cursor.sv ====
// --------------------------------------------------
// Running address and remaining length of one side
// of a transfer. Load starts a transfer, step moves
// it forward, clear drops it. Also reports the byte
// distance to the next page boundary.
// --------------------------------------------------
`default_nettype none

module side_cursor (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // New transfer
    input  logic               load_i,
    input  dma_pkg::addr_t     load_addr_i,
    input  dma_pkg::len_t      load_len_i,
    // Advance by one burst
    input  logic               step_i,
    input  dma_pkg::page_len_t step_bytes_i,
    // Kill
    input  logic               clear_i,
    output dma_pkg::addr_t     addr_o,
    output dma_pkg::len_t      remain_o,
    output logic               active_o,
    output dma_pkg::page_len_t to_page_o
);

    dma_pkg::addr_t addr_q;
    dma_pkg::len_t  remain_q;
    logic           active_q;

    // --------------------------------------------------
    // Cursor state
    // --------------------------------------------------
    // Load wins over clear, so a refill in a kill cycle
    // starts the next transfer cleanly
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            addr_q   <= '0;
            remain_q <= '0;
            active_q <= 1'b0;
        end else if (load_i) begin
            addr_q   <= load_addr_i;
            remain_q <= load_len_i;
            active_q <= 1'b1;
        end else if (clear_i) begin
            remain_q <= '0;
            active_q <= 1'b0;
        end else if (step_i) begin
            addr_q   <= addr_q + dma_pkg::addr_t'(step_bytes_i);
            remain_q <= remain_q - dma_pkg::len_t'(step_bytes_i);
            // Done once the last bytes go out
            active_q <= (remain_q != dma_pkg::len_t'(step_bytes_i));
        end
    end

    // Bytes left in the current page
    assign to_page_o = dma_pkg::page_len_t'(dma_pkg::PageSize)
                     - dma_pkg::page_len_t'(addr_q[dma_pkg::PageAddrWidth-1:0]);

    assign addr_o   = addr_q;
    assign remain_o = remain_q;
    assign active_o = active_q;

endmodule

`default_nettype wire

// ==== hdl/burst_out_reg.sv ====
// --------------------------------------------------
// Two-entry skid register for one burst stream.
// Ready toward the splitter comes from a flop, which
// breaks the ready path from the outside.
// --------------------------------------------------
`default_nettype none

module burst_out_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  payload_t in_data_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    output payload_t out_data_o,
    output logic     out_valid_o,
    input  logic     out_ready_i
);

    payload_t out_data_q;
    payload_t skid_data_q;
    logic     out_valid_q;
    logic     skid_valid_q;
    logic     out_free;
    logic     in_push;

    // Output slot empty or drained this cycle
    assign out_free = !out_valid_q | out_ready_i;
    assign in_push  = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_free) begin
            // Skid entry moves up first
            out_valid_q  <= skid_valid_q | in_push;
            skid_valid_q <= 1'b0;
        end else if (in_push) begin
            skid_valid_q <= 1'b1;
        end
    end

    // Payload path
    always_ff @(posedge clk_i) begin
        if (out_free) begin
            out_data_q <= skid_valid_q ? skid_data_q : in_data_i;
        end else if (in_push) begin
            skid_data_q <= in_data_i;
        end
    end

    assign in_ready_o  = !skid_valid_q;
    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

endmodule

`default_nettype wire

// ==== hdl/burst_splitter.sv ====
// --------------------------------------------------
// Splits the active request into page-legal read and
// write bursts. Coupled mode steps both sides by the
// nearer boundary; decoupled mode lets each side run
// on its own boundaries and its own back-pressure.
// --------------------------------------------------
`default_nettype none

module burst_splitter (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  dma_pkg::xfer_req_t req_i,
    input  logic               req_valid_i,
    output logic               req_pop_o,
    input  logic               kill_i,
    output dma_pkg::rd_burst_t rd_burst_o,
    output logic               rd_valid_o,
    input  logic               rd_ready_i,
    output dma_pkg::wr_burst_t wr_burst_o,
    output logic               wr_valid_o,
    input  logic               wr_ready_i,
    output logic               rd_busy_o,
    output logic               wr_busy_o
);

    dma_pkg::addr_t     rd_addr,    wr_addr;
    dma_pkg::len_t      rd_remain,  wr_remain;
    logic               rd_active,  wr_active;
    dma_pkg::page_len_t rd_to_page, wr_to_page;
    dma_pkg::page_len_t rd_step,    wr_step;
    dma_pkg::page_len_t rd_num,     wr_num;
    logic               rd_final,   wr_final;
    logic               rd_done,    wr_done;
    dma_pkg::page_len_t near_page;
    dma_pkg::rd_burst_t wr_fields;
    logic               load;
    logic               decouple_q;

    // --------------------------------------------------
    // Step size per side
    // --------------------------------------------------
    assign near_page = (rd_to_page < wr_to_page) ? rd_to_page : wr_to_page;
    assign rd_step   = decouple_q ? rd_to_page : near_page;
    assign wr_step   = decouple_q ? wr_to_page : near_page;

    // Last burst of a side when the rest fits in one step
    assign rd_final = (rd_remain <= dma_pkg::len_t'(rd_step));
    assign wr_final = (wr_remain <= dma_pkg::len_t'(wr_step));
    assign rd_num   = rd_final ? dma_pkg::page_len_t'(rd_remain) : rd_step;
    assign wr_num   = wr_final ? dma_pkg::page_len_t'(wr_remain) : wr_step;

    // Burst fields
    assign rd_burst_o = dma_pkg::form_burst(rd_addr, rd_num);
    assign wr_fields  = dma_pkg::form_burst(wr_addr, wr_num);
    assign wr_burst_o = '{addr:      wr_fields.addr,
                          beats:     wr_fields.beats,
                          offset:    wr_fields.offset,
                          tailer:    wr_fields.tailer,
                          num_bytes: wr_fields.num_bytes,
                          last:      wr_final};

    // --------------------------------------------------
    // Flow control
    // --------------------------------------------------
    always_comb begin
        if (decouple_q) begin
            rd_valid_o = rd_active & rd_ready_i & !kill_i;
            wr_valid_o = wr_active & wr_ready_i & !kill_i;
        end else begin
            // Both sides move in lockstep
            rd_valid_o = rd_active & wr_active & rd_ready_i & wr_ready_i & !kill_i;
            wr_valid_o = rd_valid_o;
        end
    end

    // Finished or finishing this cycle
    assign rd_done   = !rd_active | (rd_valid_o & rd_final) | kill_i;
    assign wr_done   = !wr_active | (wr_valid_o & wr_final) | kill_i;
    assign req_pop_o = rd_done & wr_done;
    assign load      = req_valid_i & req_pop_o;

    // Mode of the active transfer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            decouple_q <= 1'b0;
        end else if (load) begin
            decouple_q <= req_i.decouple_rw;
        end
    end

    side_cursor u_rd_cursor (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .load_i       (load),
        .load_addr_i  (req_i.src_addr),
        .load_len_i   (req_i.length),
        .step_i       (rd_valid_o),
        .step_bytes_i (rd_num),
        .clear_i      (kill_i),
        .addr_o       (rd_addr),
        .remain_o     (rd_remain),
        .active_o     (rd_active),
        .to_page_o    (rd_to_page)
    );

    side_cursor u_wr_cursor (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .load_i       (load),
        .load_addr_i  (req_i.dst_addr),
        .load_len_i   (req_i.length),
        .step_i       (wr_valid_o),
        .step_bytes_i (wr_num),
        .clear_i      (kill_i),
        .addr_o       (wr_addr),
        .remain_o     (wr_remain),
        .active_o     (wr_active),
        .to_page_o    (wr_to_page)
    );

    assign rd_busy_o = rd_active;
    assign wr_busy_o = wr_active;

endmodule

`default_nettype wire

// ==== hdl/dma_legalizer_top.sv ====
// --------------------------------------------------
// DMA transfer legalizer top level. Requests pass a
// two-entry queue, get split into page-legal bursts
// and leave through one skid register per stream.
// --------------------------------------------------
`default_nettype none

module dma_legalizer_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Request stream
    input  dma_pkg::xfer_req_t req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    // Read bursts
    output dma_pkg::rd_burst_t rd_burst_o,
    output logic               rd_valid_o,
    input  logic               rd_ready_i,
    // Write bursts
    output dma_pkg::wr_burst_t wr_burst_o,
    output logic               wr_valid_o,
    input  logic               wr_ready_i,
    // Control and status
    input  logic               kill_i,
    output logic               rd_busy_o,
    output logic               wr_busy_o
);

    dma_pkg::xfer_req_t q_req;
    logic               q_valid;
    logic               q_pop;
    dma_pkg::rd_burst_t sp_rd_burst;
    logic               sp_rd_valid;
    logic               sp_rd_ready;
    dma_pkg::wr_burst_t sp_wr_burst;
    logic               sp_wr_valid;
    logic               sp_wr_ready;

    xfer_fifo u_xfer_fifo (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_req_i   (req_i),
        .push_valid_i (req_valid_i),
        .push_ready_o (req_ready_o),
        .pop_req_o    (q_req),
        .pop_valid_o  (q_valid),
        .pop_ready_i  (q_pop)
    );

    burst_splitter u_burst_splitter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (q_req),
        .req_valid_i (q_valid),
        .req_pop_o   (q_pop),
        .kill_i      (kill_i),
        .rd_burst_o  (sp_rd_burst),
        .rd_valid_o  (sp_rd_valid),
        .rd_ready_i  (sp_rd_ready),
        .wr_burst_o  (sp_wr_burst),
        .wr_valid_o  (sp_wr_valid),
        .wr_ready_i  (sp_wr_ready),
        .rd_busy_o   (rd_busy_o),
        .wr_busy_o   (wr_busy_o)
    );

    // One skid stage per stream
    burst_out_reg #(.payload_t(dma_pkg::rd_burst_t)) u_rd_out (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_data_i   (sp_rd_burst),
        .in_valid_i  (sp_rd_valid),
        .in_ready_o  (sp_rd_ready),
        .out_data_o  (rd_burst_o),
        .out_valid_o (rd_valid_o),
        .out_ready_i (rd_ready_i)
    );

    burst_out_reg #(.payload_t(dma_pkg::wr_burst_t)) u_wr_out (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_data_i   (sp_wr_burst),
        .in_valid_i  (sp_wr_valid),
        .in_ready_o  (sp_wr_ready),
        .out_data_o  (wr_burst_o),
        .out_valid_o (wr_valid_o),
        .out_ready_i (wr_ready_i)
    );

endmodule

`default_nettype wire

// ==== test/dma_legalizer_props.sv ====
// --------------------------------------------------
// Handshake properties of the legalizer top level,
// bound into every dma_legalizer_top instance.
// --------------------------------------------------
`default_nettype none

module dma_legalizer_props (
    input logic               clk_i,
    input logic               rst_n_i,
    input dma_pkg::xfer_req_t req_i,
    input logic               req_valid_i,
    input logic               req_ready_i,
    input dma_pkg::rd_burst_t rd_burst_i,
    input logic               rd_valid_i,
    input logic               rd_ready_i,
    input dma_pkg::wr_burst_t wr_burst_i,
    input logic               wr_valid_i,
    input logic               wr_ready_i,
    // Splitter side of the skid registers
    input dma_pkg::rd_burst_t sp_rd_burst_i,
    input logic               sp_rd_valid_i,
    input dma_pkg::wr_burst_t sp_wr_burst_i,
    input logic               sp_wr_valid_i,
    input logic               decouple_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Stalled outputs hold
    rd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_burst_i))
        else $error("read burst changed while stalled");

    wr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_burst_i))
        else $error("write burst changed while stalled");

    // Zero-length copies are not supported
    no_zero_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i && req_ready_i |-> req_i.length != '0)
        else $error("zero-length request accepted");

    // Lockstep issue with equal byte counts in coupled mode
    coupled_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !decouple_i && (sp_rd_valid_i || sp_wr_valid_i)
            |-> sp_rd_valid_i && sp_wr_valid_i
                && sp_rd_burst_i.num_bytes == sp_wr_burst_i.num_bytes)
        else $error("coupled read and write bursts issued apart");

endmodule

bind dma_legalizer_top dma_legalizer_props u_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_i   (req_ready_o),
    .rd_burst_i    (rd_burst_o),
    .rd_valid_i    (rd_valid_o),
    .rd_ready_i    (rd_ready_i),
    .wr_burst_i    (wr_burst_o),
    .wr_valid_i    (wr_valid_o),
    .wr_ready_i    (wr_ready_i),
    .sp_rd_burst_i (sp_rd_burst),
    .sp_rd_valid_i (sp_rd_valid),
    .sp_wr_burst_i (sp_wr_burst),
    .sp_wr_valid_i (sp_wr_valid),
    .decouple_i    (u_burst_splitter.decouple_q)
);

`default_nettype wire

// ==== test/tb_dma_legalizer.sv ====
// --------------------------------------------------
// Testbench for the DMA burst legalizer. Drives
// directed and random copy requests, models the
// expected read and write bursts and compares them
// with the DUT output streams.
// --------------------------------------------------
`default_nettype none

module tb_dma_legalizer;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] Seed        = 32'h644a;
    localparam int          NumRandReqs = 24;
    localparam int          WaitLimit   = 20000;

    logic               clk;
    logic               rst_n;
    dma_pkg::xfer_req_t req;
    logic               req_valid;
    logic               req_ready;
    dma_pkg::rd_burst_t rd_burst;
    logic               rd_valid;
    logic               rd_ready;
    dma_pkg::wr_burst_t wr_burst;
    logic               wr_valid;
    logic               wr_ready;
    logic               kill;
    logic               rd_busy;
    logic               wr_busy;

    // Expected bursts with the id of their transfer
    dma_pkg::rd_burst_t rd_exp [$];
    dma_pkg::wr_burst_t wr_exp [$];
    int                 rd_ids [$];
    int                 wr_ids [$];
    bit                 killed [0:255];
    int                 next_id;
    int                 rd_errs;
    int                 wr_errs;
    int                 misc_errs;
    // 0 always ready, 1 random gaps, 2 held low
    int                 ready_mode;
    logic [31:0]        req_state;
    logic [31:0]        rdy_state;

    dma_legalizer_top u_dma_legalizer_top (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .rd_burst_o  (rd_burst),
        .rd_valid_o  (rd_valid),
        .rd_ready_i  (rd_ready),
        .wr_burst_o  (wr_burst),
        .wr_valid_o  (wr_valid),
        .wr_ready_i  (wr_ready),
        .kill_i      (kill),
        .rd_busy_o   (rd_busy),
        .wr_busy_o   (wr_busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic dma_pkg::rd_burst_t expect_rd(input dma_pkg::addr_t a, input int n);
        dma_pkg::rd_burst_t b;
        int                 off;
        off         = int'(a % dma_pkg::StrbWidth);
        // Aligned down to the beat
        b.addr      = a - dma_pkg::addr_t'(off);
        b.beats     = dma_pkg::BeatCntWidth'((off + n - 1) / dma_pkg::StrbWidth);
        b.offset    = dma_pkg::offset_t'(off);
        b.tailer    = dma_pkg::offset_t'((off + n) % dma_pkg::StrbWidth);
        b.num_bytes = dma_pkg::page_len_t'(n);
        return b;
    endfunction

    function automatic dma_pkg::wr_burst_t expect_wr(input dma_pkg::addr_t a, input int n,
                                                     input logic last);
        dma_pkg::rd_burst_t rb;
        dma_pkg::wr_burst_t wb;
        rb           = expect_rd(a, n);
        wb.addr      = rb.addr;
        wb.beats     = rb.beats;
        wb.offset    = rb.offset;
        wb.tailer    = rb.tailer;
        wb.num_bytes = rb.num_bytes;
        wb.last      = last;
        return wb;
    endfunction

    // Splits one request and queues its bursts
    function automatic void model_xfer(input dma_pkg::xfer_req_t r, input int id);
        dma_pkg::addr_t rd_a;
        dma_pkg::addr_t wr_a;
        int             rd_left;
        int             wr_left;
        int             rd_pg;
        int             wr_pg;
        int             n;
        rd_a    = r.src_addr;
        wr_a    = r.dst_addr;
        rd_left = int'(r.length);
        wr_left = int'(r.length);
        while (rd_left > 0 || wr_left > 0) begin
            rd_pg = dma_pkg::PageSize - int'(rd_a % dma_pkg::PageSize);
            wr_pg = dma_pkg::PageSize - int'(wr_a % dma_pkg::PageSize);
            // Coupled: nearer boundary for both
            if (!r.decouple_rw) begin
                rd_pg = (rd_pg < wr_pg) ? rd_pg : wr_pg;
                wr_pg = rd_pg;
            end
            if (rd_left > 0) begin
                n = (rd_left < rd_pg) ? rd_left : rd_pg;
                rd_exp.push_back(expect_rd(rd_a, n));
                rd_ids.push_back(id);
                rd_a    = rd_a + dma_pkg::addr_t'(n);
                rd_left = rd_left - n;
            end
            if (wr_left > 0) begin
                n = (wr_left < wr_pg) ? wr_left : wr_pg;
                wr_exp.push_back(expect_wr(wr_a, n, n == wr_left));
                wr_ids.push_back(id);
                wr_a    = wr_a + dma_pkg::addr_t'(n);
                wr_left = wr_left - n;
            end
        end
    endfunction

    // Expected bursts not belonging to a killed transfer
    function automatic int pending();
        int cnt;
        cnt = 0;
        foreach (rd_ids[i]) begin
            if (!killed[rd_ids[i]]) cnt++;
        end
        foreach (wr_ids[i]) begin
            if (!killed[wr_ids[i]]) cnt++;
        end
        return cnt;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_rd(input dma_pkg::rd_burst_t got);
        dma_pkg::rd_burst_t exp;
        int                 kid;
        // Rest of a killed transfer ends at its first mismatch
        while (rd_exp.size() != 0 && killed[rd_ids[0]] && rd_exp[0] !== got) begin
            kid = rd_ids[0];
            while (rd_exp.size() != 0 && rd_ids[0] == kid) begin
                void'(rd_exp.pop_front());
                void'(rd_ids.pop_front());
            end
        end
        if (rd_exp.size() == 0) begin
            rd_errs++;
            $display("At %0t a read burst arrived with none expected", $time);
        end else begin
            exp = rd_exp.pop_front();
            void'(rd_ids.pop_front());
            if (got !== exp) begin
                rd_errs++;
                $display("[ERROR] %0t: read burst got %h expected %h", $time, got, exp);
            end
        end
    endtask

    task automatic check_wr(input dma_pkg::wr_burst_t got);
        dma_pkg::wr_burst_t exp;
        int                 kid;
        while (wr_exp.size() != 0 && killed[wr_ids[0]] && wr_exp[0] !== got) begin
            kid = wr_ids[0];
            while (wr_exp.size() != 0 && wr_ids[0] == kid) begin
                void'(wr_exp.pop_front());
                void'(wr_ids.pop_front());
            end
        end
        if (wr_exp.size() == 0) begin
            wr_errs++;
            $display("At %0t a write burst arrived with none expected", $time);
        end else begin
            exp = wr_exp.pop_front();
            void'(wr_ids.pop_front());
            if (got !== exp) begin
                wr_errs++;
                $display("[ERROR] %0t: write burst got %h expected %h", $time, got, exp);
            end
        end
    endtask

    // Accepted outputs, seen before the flops update
    always @(posedge clk) begin
        if (rst_n) begin
            if (rd_valid && rd_ready) check_rd(rd_burst);
            if (wr_valid && wr_ready) check_wr(wr_burst);
        end
    end

    // Ready gaps, own random stream
    always @(negedge clk) begin
        case (ready_mode)
            1: begin
                rdy_state = xorshift(rdy_state);
                rd_ready  = rdy_state[0] | rdy_state[1];
                wr_ready  = rdy_state[2] | rdy_state[3];
            end
            2: begin
                rd_ready = 1'b0;
                wr_ready = 1'b0;
            end
            default: begin
                rd_ready = 1'b1;
                wr_ready = 1'b1;
            end
        endcase
    end

    // --------------------------------------------------
    // Stimulus tasks, all return on a falling edge
    // --------------------------------------------------
    task automatic set_ready_mode(input int m);
        @(posedge clk);
        ready_mode = m;
        @(negedge clk);
    endtask

    task automatic send_req(input dma_pkg::xfer_req_t r);
        int cnt;
        cnt       = 0;
        req       = r;
        req_valid = 1'b1;
        while (!req_ready && cnt < WaitLimit) begin
            @(negedge clk);
            cnt++;
        end
        if (!req_ready) begin
            misc_errs++;
            $display("Timeout: the request queue never accepted a request");
        end else begin
            // Accepted at the coming rising edge
            model_xfer(r, next_id);
            next_id++;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic send(input int len, input logic [31:0] src, input logic [31:0] dst,
                        input logic dec);
        dma_pkg::xfer_req_t r;
        r.length      = dma_pkg::len_t'(len);
        r.src_addr    = src;
        r.dst_addr    = dst;
        r.decouple_rw = dec;
        send_req(r);
    endtask

    task automatic send_random();
        int          len;
        logic [31:0] src;
        logic [31:0] dst;
        req_state = xorshift(req_state);
        len       = int'(req_state % 3000) + 1;
        req_state = xorshift(req_state);
        src       = req_state;
        req_state = xorshift(req_state);
        dst       = req_state;
        req_state = xorshift(req_state);
        send(len, src, dst, req_state[7]);
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while ((pending() != 0 || rd_busy || wr_busy || rd_valid || wr_valid)
               && cnt < WaitLimit) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= WaitLimit) begin
            misc_errs++;
            $display("Timeout: the DUT did not drain its expected bursts");
        end
    endtask

    task automatic wait_both_valid();
        int cnt;
        cnt = 0;
        while (!(rd_valid && wr_valid) && cnt < WaitLimit) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= WaitLimit) begin
            misc_errs++;
            $display("Timeout: no read and write bursts appeared before the kill");
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        rst_n      = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        kill       = 1'b0;
        rd_ready   = 1'b1;
        wr_ready   = 1'b1;
        ready_mode = 0;
        next_id    = 0;
        rd_errs    = 0;
        wr_errs    = 0;
        misc_errs  = 0;
        req_state  = Seed;
        rdy_state  = xorshift(Seed);
        foreach (killed[i]) killed[i] = 1'b0;

        repeat (10) @(negedge clk);
        if (req_ready || rd_valid || wr_valid || rd_busy || wr_busy) begin
            misc_errs++;
            $display("[ERROR] %0t: outputs not idle during reset", $time);
        end
        rst_n = 1'b1;
        @(negedge clk);
        if (!req_ready) begin
            misc_errs++;
            $display("[ERROR] %0t: req_ready low after reset", $time);
        end

        // Single page, coupled
        send(40, 32'h0000_0101, 32'h0000_2203, 1'b0);
        wait_idle();
        // Coupled across misaligned pages
        send(2500, 32'h0000_03f0, 32'h0001_0005, 1'b0);
        wait_idle();
        // Decoupled, each side on its own pages
        send(2000, 32'h0000_01f7, 32'h0000_8a02, 1'b1);
        wait_idle();

        // Random requests under random back-pressure
        set_ready_mode(1);
        for (int i = 0; i < NumRandReqs; i++) begin
            send_random();
        end
        wait_idle();
        set_ready_mode(0);

        // Back-to-back, second one queued behind the first
        send(1500, 32'h0000_0322, 32'h0000_5bfe, 1'b0);
        send(900, 32'h0000_7001, 32'h0000_0ff3, 1'b1);
        wait_idle();

        // Kill with the output registers full
        set_ready_mode(2);
        send(3000, 32'h0000_0010, 32'h0000_4004, 1'b0);
        wait_both_valid();
        // Cursors still hold most of the transfer
        if (!rd_busy || !wr_busy) begin
            misc_errs++;
            $display("[ERROR] %0t: busy low during an active transfer", $time);
        end
        kill                 = 1'b1;
        killed[next_id - 1]  = 1'b1;
        @(negedge clk);
        kill = 1'b0;
        if (rd_busy || wr_busy) begin
            misc_errs++;
            $display("[ERROR] %0t: busy still high after kill", $time);
        end
        send(700, 32'h0000_03f8, 32'h0000_07c0, 1'b1);
        set_ready_mode(0);
        wait_idle();

        $display("Errors: read %0d, write %0d, other %0d", rd_errs, wr_errs, misc_errs);
        if (rd_errs + wr_errs + misc_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/dma_pkg.sv
hdl/xfer_fifo.sv
hdl/side_cursor.sv
hdl/burst_out_reg.sv
hdl/burst_splitter.sv
hdl/dma_legalizer_top.sv
test/dma_legalizer_props.sv
test/tb_dma_legalizer.sv

// ==== Bender.yml ====
package:
  name: dma_legalizer

sources:
  - hdl/dma_pkg.sv
  - hdl/xfer_fifo.sv
  - hdl/side_cursor.sv
  - hdl/burst_out_reg.sv
  - hdl/burst_splitter.sv
  - hdl/dma_legalizer_top.sv
  - target: test
    files:
      - test/dma_legalizer_props.sv
      - test/tb_dma_legalizer.sv
